/* x86_arch_pkg.sv */
/*
 * x86 architectural state definitions
 * Register counts and widths, register numbers and the GPR writeback word
 */
`default_nettype none

package x86_arch_pkg;

    // Register file sizes
    localparam int GPR_COUNT = 8;
    localparam int SEG_COUNT = 6;
    localparam int MMX_COUNT = 8;

    localparam int GPR_W = 32;
    localparam int SEG_W = 16;
    localparam int MMX_W = 64;

    // EAX ECX EDX EBX ESP EBP ESI EDI
    typedef logic [2:0] gpr_idx_t;

    // ES CS SS DS FS GS, values 6 and 7 unused
    typedef logic [2:0] seg_idx_t;

    typedef logic [2:0] mmx_idx_t;

    // Operand kind from decode
    typedef logic [2:0] op_kind_t;

    // Register taken from ModRM rm
    localparam op_kind_t OP_KIND_MODRM_REG = 3'd4;

    // Writeback size in bytes
    typedef logic [2:0] wb_size_t;

    localparam wb_size_t WB_SIZE_BYTE  = 3'd1;
    localparam wb_size_t WB_SIZE_WORD  = 3'd2;
    localparam wb_size_t WB_SIZE_DWORD = 3'd4;

    // Writeback word, seen whole or split into bytes
    typedef union packed {
        logic [GPR_W-1:0] dword;
        struct packed {
            logic [15:0] upper;
            logic [7:0]  high;
            logic [7:0]  low;
        } parts;
    } gpr_wdata_u;

endpackage

`default_nettype wire

/* ra_stage_pkg.sv */
/*
 * Register access stage bundles
 * Decode input, register snapshot, stage output and writeback ports
 */
`default_nettype none

package ra_stage_pkg;

    import x86_arch_pkg::*;

    // Decoded instruction fields
    typedef struct packed {
        logic [2:0]  size;
        logic        set_d_flag;
        logic        clear_d_flag;
        op_kind_t    op0;
        op_kind_t    op1;
        gpr_idx_t    op0_reg;
        gpr_idx_t    op1_reg;
        logic [7:0]  modrm;
        logic [7:0]  sib;
        logic [47:0] imm;
        logic [31:0] disp;
        logic [3:0]  alu_op;
        logic [2:0]  flag_0;
        logic [2:0]  flag_1;
        logic [1:0]  stack_op;
        seg_idx_t    seg_override;
        logic        seg_override_valid;
        logic [31:0] pc;
        logic        branch_taken;
        logic [15:0] opcode;
    } decode_bundle_t;

    // Whole architectural register state
    typedef struct packed {
        logic [GPR_COUNT-1:0][GPR_W-1:0] gpr;
        logic [SEG_COUNT-1:0][SEG_W-1:0] seg;
        logic [MMX_COUNT-1:0][MMX_W-1:0] mmx;
    } reg_snapshot_t;

    // Operand registers in dec are already resolved
    typedef struct packed {
        decode_bundle_t dec;
        reg_snapshot_t  regs;
    } stage_out_t;

    typedef struct packed {
        logic       en;
        gpr_idx_t   number;
        wb_size_t   size;
        gpr_wdata_u data;
    } gpr_wb_t;

    typedef struct packed {
        logic             en;
        seg_idx_t         number;
        logic [SEG_W-1:0] data;
    } seg_wb_t;

    typedef struct packed {
        logic             en;
        mmx_idx_t         number;
        logic [MMX_W-1:0] data;
    } mmx_wb_t;

endpackage

`default_nettype wire

/* register_file.sv */
/*
 * General purpose register file
 * Eight 32-bit registers, byte/word/dword writeback, all read out at once
 */
`timescale 1ns/1ns
`default_nettype none

module register_file
    import x86_arch_pkg::*;
    import ra_stage_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire gpr_wb_t                         wb,
    output logic [GPR_COUNT-1:0][GPR_W-1:0]      gprs
);

    logic [GPR_COUNT-1:0][GPR_W-1:0] gpr_q;

    gpr_idx_t         wr_idx;
    logic [GPR_W-1:0] wr_val;
    logic             wr_en;

    // Merge the writeback into the current register value
    always_comb begin
        wr_idx = wb.number;
        wr_val = gpr_q[wb.number];
        wr_en  = wb.en;
        case (wb.size)
            WB_SIZE_DWORD: begin
                wr_val = wb.data.dword;
            end
            WB_SIZE_WORD: begin
                wr_val[15:0] = {wb.data.parts.high, wb.data.parts.low};
            end
            WB_SIZE_BYTE: begin
                if (wb.number[2]) begin
                    // AH/CH/DH/BH live in bits 15:8 of EAX..EBX
                    wr_idx        = {1'b0, wb.number[1:0]};
                    wr_val        = gpr_q[wr_idx];
                    wr_val[15:8]  = wb.data.parts.low;
                end else begin
                    wr_val[7:0] = wb.data.parts.low;
                end
            end
            default: begin
                // Unknown size, drop the write
                wr_en = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpr_q <= '0;
        end else if (wr_en) begin
            gpr_q[wr_idx] <= wr_val;
        end
    end

    assign gprs = gpr_q;

endmodule

`default_nettype wire

/* segment_register_file.sv */
/*
 * Segment register file
 * Six 16-bit registers, one write port, all read out at once
 */
`timescale 1ns/1ns
`default_nettype none

module segment_register_file
    import x86_arch_pkg::*;
    import ra_stage_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire seg_wb_t                         wb,
    output logic [SEG_COUNT-1:0][SEG_W-1:0]      segs
);

    logic [SEG_COUNT-1:0][SEG_W-1:0] seg_q;
    logic                            wr_hit;

    // Indices 6 and 7 name no register
    assign wr_hit = wb.en && (wb.number < seg_idx_t'(SEG_COUNT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_q <= '0;
        end else if (wr_hit) begin
            seg_q[wb.number] <= wb.data;
        end
    end

    assign segs = seg_q;

endmodule

`default_nettype wire

/* mmx_register_file.sv */
/*
 * MMX register file
 * Eight 64-bit registers, one write port, all read out at once
 */
`timescale 1ns/1ns
`default_nettype none

module mmx_register_file
    import x86_arch_pkg::*;
    import ra_stage_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire mmx_wb_t                         wb,
    output logic [MMX_COUNT-1:0][MMX_W-1:0]      mmxs
);

    logic [MMX_COUNT-1:0][MMX_W-1:0] mmx_q;

    // MM0..MM7
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mmx_q <= '0;
        end else if (wb.en) begin
            mmx_q[wb.number] <= wb.data;
        end
    end

    assign mmxs = mmx_q;

endmodule

`default_nettype wire

/* ra_skid_buffer.sv */
/*
 * Register access stage buffer
 * Two-entry valid/ready FIFO for the stage output, with synchronous flush
 */
`timescale 1ns/1ns
`default_nettype none

module ra_skid_buffer
    import ra_stage_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       flush,
    input  wire logic       in_valid,
    output logic            in_ready,
    input  wire stage_out_t in_data,
    output logic            out_valid,
    input  wire logic       out_ready,
    output stage_out_t      out_data
);

    stage_out_t mem [2];

    logic [1:0] count;
    logic       head;
    logic       tail;
    logic       push;
    logic       pop;

    // Full only with two entries; flush cycle accepts and discards
    assign in_ready  = flush || (count != 2'd2);
    // Nothing leaves during a flush
    assign out_valid = (count != 2'd0) && !flush;
    assign out_data  = mem[head];

    assign push = in_valid && in_ready && !flush;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= 2'd0;
            head  <= 1'b0;
            tail  <= 1'b0;
        end else if (flush) begin
            count <= 2'd0;
            head  <= 1'b0;
            tail  <= 1'b0;
        end else begin
            if (push) begin
                tail <= ~tail;
            end
            if (pop) begin
                head <= ~head;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= in_data;
        end
    end

endmodule

`default_nettype wire

/* register_access_top.sv */
/*
 * Register access stage
 * Resolves operand registers, snapshots GPR/segment/MMX state on accept
 * and hands the bundle to address generation through a two-entry buffer
 */
`timescale 1ns/1ns
`default_nettype none

module register_access_top
    import x86_arch_pkg::*;
    import ra_stage_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           flush,

    // Decode side
    input  wire logic           d_valid,
    output logic                d_ready,
    input  wire decode_bundle_t d,

    // Address generation side
    output logic                r_valid,
    input  wire logic           r_ready,
    output stage_out_t          r,

    // Writeback
    input  wire gpr_wb_t        gpr_wb,
    input  wire seg_wb_t        seg_wb,
    input  wire mmx_wb_t        mmx_wb
);

    logic [GPR_COUNT-1:0][GPR_W-1:0] gprs;
    logic [SEG_COUNT-1:0][SEG_W-1:0] segs;
    logic [MMX_COUNT-1:0][MMX_W-1:0] mmxs;

    stage_out_t buf_in;

    // Kind 4 takes the register from ModRM rm
    function automatic gpr_idx_t resolve_reg(
        input op_kind_t   kind,
        input logic [7:0] modrm,
        input gpr_idx_t   dec_reg
    );
        gpr_idx_t sel;
        sel = (kind == OP_KIND_MODRM_REG) ? modrm[2:0] : dec_reg;
        return sel;
    endfunction

    always_comb begin
        buf_in             = '0;
        buf_in.dec         = d;
        buf_in.dec.op0_reg = resolve_reg(d.op0, d.modrm, d.op0_reg);
        buf_in.dec.op1_reg = resolve_reg(d.op1, d.modrm, d.op1_reg);
        buf_in.regs.gpr    = gprs;
        buf_in.regs.seg    = segs;
        buf_in.regs.mmx    = mmxs;
    end

    register_file register_file0 (
        .clk   (clk),
        .rst_n (rst_n),
        .wb    (gpr_wb),
        .gprs  (gprs)
    );

    segment_register_file segment_register_file0 (
        .clk   (clk),
        .rst_n (rst_n),
        .wb    (seg_wb),
        .segs  (segs)
    );

    mmx_register_file mmx_register_file0 (
        .clk   (clk),
        .rst_n (rst_n),
        .wb    (mmx_wb),
        .mmxs  (mmxs)
    );

    // One cycle from accept to r_valid
    ra_skid_buffer stage_buffer0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (d_valid),
        .in_ready  (d_ready),
        .in_data   (buf_in),
        .out_valid (r_valid),
        .out_ready (r_ready),
        .out_data  (r)
    );

endmodule

`default_nettype wire

/* register_access_sva.sv */
/*
 * Register access stage assertions
 * Reset, stall stability and flush rules on the output handshake
 */
`timescale 1ns/1ns
`default_nettype none

module register_access_sva
    import ra_stage_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic       flush,
    input wire logic       r_valid,
    input wire logic       r_ready,
    input wire stage_out_t r
);

    // Quiet output in reset and on the first edge out of it
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !r_valid)
        else $error("r_valid high during reset");
    reset_exit_quiet: assert property (@(posedge clk) !rst_n |=> !r_valid)
        else $error("r_valid high just after reset");

    // A stalled output holds until taken, unless flushed
    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (r_valid && !r_ready) |=> (flush || (r_valid && $stable(r))))
        else $error("r dropped or changed while stalled");

    flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !r_valid)
        else $error("r_valid high after a flush");

endmodule

`default_nettype wire

/* tb_register_access.sv */
/*
 * Register access stage testbench
 * Shadow register model, expected output queue and random back-pressure
 */
`timescale 1ns/1ns
`default_nettype none

module tb_register_access
    import x86_arch_pkg::*;
    import ra_stage_pkg::*;
();

    localparam int RESET_CYCLES = 3;
    // Cycle budget of the six tests in order, plus slack
    localparam int CYCLE_LIMIT = RESET_CYCLES + 10 + 90 + 70 + 40 + 160 + 30 + 200;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           flush;
    logic           d_valid;
    logic           d_ready;
    decode_bundle_t d;
    logic           r_valid;
    logic           r_ready;
    stage_out_t     r;
    gpr_wb_t        gpr_wb;
    seg_wb_t        seg_wb;
    mmx_wb_t        mmx_wb;

    logic [GPR_COUNT-1:0][GPR_W-1:0] sh_gpr;
    logic [SEG_COUNT-1:0][SEG_W-1:0] sh_seg;
    logic [MMX_COUNT-1:0][MMX_W-1:0] sh_mmx;
    stage_out_t exp_q[$];
    stage_out_t exp_head;
    int         seed = 93358;
    int         checks = 0;
    int         errors = 0;
    int         outputs = 0;
    int         cycles = 0;
    logic       rand_ready = 1'b0;

    always #20 clk = ~clk;

    register_access_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .d_valid (d_valid),
        .d_ready (d_ready),
        .d       (d),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r       (r),
        .gpr_wb  (gpr_wb),
        .seg_wb  (seg_wb),
        .mmx_wb  (mmx_wb)
    );

    bind register_access_top register_access_sva sva0 (
        .clk(clk), .rst_n(rst_n), .flush(flush), .r_valid(r_valid), .r_ready(r_ready), .r(r)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    // Kind 4 means the ModRM rm field names the register
    function automatic stage_out_t expected_out(input decode_bundle_t dd);
        stage_out_t e;
        e.dec = dd;
        if (dd.op0 == OP_KIND_MODRM_REG) e.dec.op0_reg = dd.modrm[2:0];
        if (dd.op1 == OP_KIND_MODRM_REG) e.dec.op1_reg = dd.modrm[2:0];
        e.regs.gpr = sh_gpr;
        e.regs.seg = sh_seg;
        e.regs.mmx = sh_mmx;
        return e;
    endfunction

    task automatic shadow_gpr_write(input gpr_wb_t w);
        logic [31:0] v;
        v = w.data.dword;
        case (w.size)
            WB_SIZE_DWORD: sh_gpr[w.number] = v;
            WB_SIZE_WORD:  sh_gpr[w.number][15:0] = v[15:0];
            WB_SIZE_BYTE: begin
                // Numbers 4..7 are AH/CH/DH/BH
                if (w.number >= 3'd4) sh_gpr[w.number - 3'd4][15:8] = v[7:0];
                else sh_gpr[w.number][7:0] = v[7:0];
            end
            default: ;
        endcase
    endtask

    // Checks and model updates at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check(d_ready == (flush || exp_q.size() < 2), "d_ready disagrees with held entries");
            check(r_valid == (exp_q.size() != 0 && !flush), "r_valid disagrees with held entries");
            if (r_valid && r_ready && exp_q.size() != 0) begin
                exp_head = exp_q.pop_front();
                check(r == exp_head, "stage output differs from the expected bundle");
                if (outputs == 0) check(r.regs == '0, "first snapshot is not all zero");
                outputs++;
            end
            if (flush) exp_q.delete();
            else if (d_valid && d_ready) exp_q.push_back(expected_out(d));
            // Writes land at the coming edge, after this accept
            if (gpr_wb.en) shadow_gpr_write(gpr_wb);
            if (seg_wb.en && seg_wb.number < 3'd6) sh_seg[seg_wb.number] = seg_wb.data;
            if (mmx_wb.en) sh_mmx[mmx_wb.number] = mmx_wb.data;
        end
    end

    task automatic step();
        logic [31:0] v;
        @(posedge clk);
        #2;
        if (rand_ready) begin
            v = $random(seed);
            r_ready = v[0];
        end
    endtask

    function automatic decode_bundle_t random_bundle();
        logic [191:0] bits;
        bits = {$random(seed), $random(seed), $random(seed),
                $random(seed), $random(seed), $random(seed)};
        return decode_bundle_t'(bits[$bits(decode_bundle_t)-1:0]);
    endfunction

    task automatic send_instr(input decode_bundle_t dd);
        logic taken;
        taken = 1'b0;
        d = dd;
        d_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = d_ready;
            step();
        end
        d_valid = 1'b0;
    endtask

    task automatic drain();
        rand_ready = 1'b0;
        r_ready = 1'b1;
        while (exp_q.size() != 0) step();
        step();
    endtask

    // Instruction in the write cycle sees the old state and the next one the new
    task automatic pulse_write();
        d = random_bundle();
        d_valid = 1'b1;
        step();
        d_valid = 1'b0;
        gpr_wb.en = 1'b0;
        seg_wb.en = 1'b0;
        mmx_wb.en = 1'b0;
        send_instr(random_bundle());
    endtask

    task automatic write_gpr(input gpr_idx_t num, input wb_size_t size, input logic [31:0] val);
        gpr_wb = {1'b1, num, size, val};
        pulse_write();
    endtask

    task automatic write_seg(input seg_idx_t num, input logic [15:0] val);
        seg_wb = {1'b1, num, val};
        pulse_write();
    endtask

    task automatic write_mmx(input mmx_idx_t num, input logic [63:0] val);
        mmx_wb = {1'b1, num, val};
        pulse_write();
    endtask

    task automatic report_test(input int num, input string name, input int mark);
        if (errors == mark) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: %0d errors", num, name, errors - mark);
        end
    endtask

    initial begin
        int             mark;
        decode_bundle_t b;
        rst_n = 1'b0;
        flush = 1'b0;
        d_valid = 1'b0;
        d = '0;
        r_ready = 1'b1;
        gpr_wb = '0;
        seg_wb = '0;
        mmx_wb = '0;
        sh_gpr = '0;
        sh_seg = '0;
        sh_mmx = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        mark = errors;
        repeat (3) step();
        send_instr(random_bundle());
        drain();
        report_test(1, "reset state", mark);

        mark = errors;
        for (int i = 0; i < 8; i++) write_gpr(gpr_idx_t'(i), WB_SIZE_DWORD, $random(seed));
        for (int i = 0; i < 8; i += 2) write_gpr(gpr_idx_t'(i), WB_SIZE_WORD, $random(seed));
        for (int i = 0; i < 8; i++) write_gpr(gpr_idx_t'(i), WB_SIZE_BYTE, $random(seed));
        drain();
        report_test(2, "GPR writeback sizes", mark);

        mark = errors;
        for (int i = 0; i < 8; i++) write_seg(seg_idx_t'(i), 16'($random(seed)));
        for (int i = 0; i < 8; i++) write_mmx(mmx_idx_t'(i), {$random(seed), $random(seed)});
        drain();
        report_test(3, "segment and MMX writeback", mark);

        mark = errors;
        for (int i = 0; i < 16; i++) begin
            b = random_bundle();
            b.op0 = (i % 2 == 0) ? OP_KIND_MODRM_REG : op_kind_t'(i % 4);
            b.op1 = (i % 3 == 0) ? OP_KIND_MODRM_REG : op_kind_t'(2);
            send_instr(b);
        end
        drain();
        report_test(4, "operand register select", mark);

        mark = errors;
        rand_ready = 1'b1;
        for (int i = 0; i < 40; i++) send_instr(random_bundle());
        drain();
        report_test(5, "random back-pressure", mark);

        mark = errors;
        r_ready = 1'b0;
        send_instr(random_bundle());
        send_instr(random_bundle());
        d = random_bundle();
        d_valid = 1'b1;
        flush = 1'b1;
        step();
        flush = 1'b0;
        d_valid = 1'b0;
        send_instr(random_bundle());
        send_instr(random_bundle());
        drain();
        report_test(6, "flush", mark);

        $display("Tests: 6, checks: %0d, errors: %0d, outputs: %0d", checks, errors, outputs);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* register_access.f */
x86_arch_pkg.sv
ra_stage_pkg.sv
register_file.sv
segment_register_file.sv
mmx_register_file.sv
ra_skid_buffer.sv
register_access_top.sv
register_access_sva.sv
tb_register_access.sv

/* run.sh */
#!/bin/sh
# Build and run the register access testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_register_access -f register_access.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_register_access 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
